/* rtl/noc_ni_pkg.sv */
/*
 * Shared definitions of the NoC network interface
 * AXI widths and vector types, channel codes, request and response
 * flit layout, and the fixed system address map
 */
package noc_ni_pkg;

  //////////////////////////////////////////////////////////////////////
  // AXI widths and types
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned IdWidth     = 4;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned LenWidth    = 8;
  localparam int unsigned RespWidth   = 2;
  localparam int unsigned NodeIdWidth = 4;

  typedef logic [AddrWidth-1:0]   axi_addr_t;
  typedef logic [IdWidth-1:0]     axi_id_t;
  typedef logic [DataWidth-1:0]   axi_data_t;
  typedef logic [StrbWidth-1:0]   axi_strb_t;
  typedef logic [LenWidth-1:0]    axi_len_t;
  typedef logic [RespWidth-1:0]   axi_resp_t;
  typedef logic [NodeIdWidth-1:0] node_id_t;

  // Channel code carried in every flit header
  typedef enum logic [2:0] {
    AXI_AW = 3'd0,
    AXI_W  = 3'd1,
    AXI_AR = 3'd2,
    AXI_B  = 3'd3,
    AXI_R  = 3'd4
  } axi_ch_e;

  //////////////////////////////////////////////////////////////////////
  // Flit layout
  //////////////////////////////////////////////////////////////////////

  // Header fields, offsets relative to the header LSB
  localparam int unsigned HdrWidth   = 12;
  localparam int unsigned HdrLastBit = 0;
  localparam int unsigned HdrChLsb   = 1;
  localparam int unsigned HdrChWidth = 3;
  localparam int unsigned HdrSrcLsb  = 4;
  localparam int unsigned HdrDstLsb  = 8;

  localparam int unsigned ReqPayloadWidth = 48;
  localparam int unsigned RspPayloadWidth = 40;

  // Header sits directly above the payload
  localparam int unsigned ReqHdrLsb    = ReqPayloadWidth;
  localparam int unsigned RspHdrLsb    = RspPayloadWidth;
  localparam int unsigned ReqFlitWidth = HdrWidth + ReqPayloadWidth;
  localparam int unsigned RspFlitWidth = HdrWidth + RspPayloadWidth;

  typedef logic [ReqFlitWidth-1:0] req_flit_t;
  typedef logic [RspFlitWidth-1:0] rsp_flit_t;

  // AW and AR payload {id, addr, len}
  localparam int unsigned AxLenLsb  = 0;
  localparam int unsigned AxAddrLsb = AxLenLsb + LenWidth;
  localparam int unsigned AxIdLsb   = AxAddrLsb + AddrWidth;

  // W payload {data, strb, last}
  localparam int unsigned WLastBit = 0;
  localparam int unsigned WStrbLsb = 1;
  localparam int unsigned WDataLsb = WStrbLsb + StrbWidth;

  // B payload {id, resp}
  localparam int unsigned BRespLsb = 0;
  localparam int unsigned BIdLsb   = BRespLsb + RespWidth;

  // R payload {id, data, resp, last}
  localparam int unsigned RLastBit = 0;
  localparam int unsigned RRespLsb = 1;
  localparam int unsigned RDataLsb = RRespLsb + RespWidth;
  localparam int unsigned RIdLsb   = RDataLsb + DataWidth;

  //////////////////////////////////////////////////////////////////////
  // System address map
  //////////////////////////////////////////////////////////////////////

  // Top address nibble picks the region, regions 0 to 3 are mapped
  localparam int unsigned SamNumRules  = 4;
  localparam int unsigned SamRegionMsb = 31;
  localparam int unsigned SamRegionLsb = 28;

  localparam node_id_t [SamNumRules-1:0] SamNodeIds = {
    node_id_t'(10), node_id_t'(9), node_id_t'(6), node_id_t'(5)
  };

  // Unmapped addresses land here
  localparam node_id_t DefaultNodeId = node_id_t'(0);

endpackage

/* rtl/ax_spill_reg.sv */
`timescale 1ns/1ps
/*
 * Two-entry spill register for one AW or AR channel
 * Registered output, full throughput, ready cut from the downstream side
 */
module ax_spill_reg (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  noc_ni_pkg::axi_addr_t addr_i,
  input  noc_ni_pkg::axi_id_t   id_i,
  input  noc_ni_pkg::axi_len_t  len_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output noc_ni_pkg::axi_addr_t addr_o,
  output noc_ni_pkg::axi_id_t   id_o,
  output noc_ni_pkg::axi_len_t  len_o
);
  import noc_ni_pkg::*;

  // Output slot feeds downstream; spill slot catches a beat during a stall
  logic      out_full_q, spill_full_q;
  axi_addr_t out_addr_q, spill_addr_q;
  axi_id_t   out_id_q, spill_id_q;
  axi_len_t  out_len_q, spill_len_q;
  logic      in_xfer, out_xfer, to_spill;

  assign ready_o  = !spill_full_q;
  assign valid_o  = out_full_q;
  assign addr_o   = out_addr_q;
  assign id_o     = out_id_q;
  assign len_o    = out_len_q;

  assign in_xfer  = valid_i && ready_o;
  assign out_xfer = out_full_q && ready_i;
  // New beat parks in the spill slot when the output slot cannot drain
  assign to_spill = in_xfer && out_full_q && !out_xfer;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_full_q   <= 1'b0;
      spill_full_q <= 1'b0;
    end else if (spill_full_q) begin
      if (out_xfer) begin
        spill_full_q <= 1'b0;
      end
    end else if (to_spill) begin
      spill_full_q <= 1'b1;
    end else if (in_xfer) begin
      out_full_q <= 1'b1;
    end else if (out_xfer) begin
      out_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (spill_full_q && out_xfer) begin
      out_addr_q <= spill_addr_q;
      out_id_q   <= spill_id_q;
      out_len_q  <= spill_len_q;
    end else if (to_spill) begin
      spill_addr_q <= addr_i;
      spill_id_q   <= id_i;
      spill_len_q  <= len_i;
    end else if (in_xfer) begin
      out_addr_q <= addr_i;
      out_id_q   <= id_i;
      out_len_q  <= len_i;
    end
  end

  // A stalled request is never withdrawn
  a_valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o);

endmodule

/* rtl/req_flit_packer.sv */
`timescale 1ns/1ps
/*
 * Request flit packer
 * Address map lookup, AW/W sequencing FSM, AW, W and AR flit building
 */
module req_flit_packer (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  noc_ni_pkg::node_id_t  node_id_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  noc_ni_pkg::axi_addr_t aw_addr_i,
  input  noc_ni_pkg::axi_id_t   aw_id_i,
  input  noc_ni_pkg::axi_len_t  aw_len_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  noc_ni_pkg::axi_data_t w_data_i,
  input  noc_ni_pkg::axi_strb_t w_strb_i,
  input  logic                  w_last_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  noc_ni_pkg::axi_addr_t ar_addr_i,
  input  noc_ni_pkg::axi_id_t   ar_id_i,
  input  noc_ni_pkg::axi_len_t  ar_len_i,
  output logic                  wa_valid_o,
  input  logic                  wa_grant_i,
  output noc_ni_pkg::req_flit_t wa_flit_o,
  output logic                  ar_valid_o,
  input  logic                  ar_grant_i,
  output noc_ni_pkg::req_flit_t ar_flit_o
);
  import noc_ni_pkg::*;

  typedef enum logic {SEL_AW, SEL_W} aw_w_sel_e;

  aw_w_sel_e sel_q, sel_d;
  node_id_t  aw_dst, ar_dst, w_dst_q;
  req_flit_t aw_flit, w_flit;
  logic      aw_xfer, w_xfer;

  //////////////////////////////////////////////////////////////////////
  // Routing and flit helpers
  //////////////////////////////////////////////////////////////////////

  function automatic node_id_t sam_lookup(axi_addr_t addr);
    node_id_t dst;
    dst = DefaultNodeId;
    for (int unsigned i = 0; i < SamNumRules; i++) begin
      if (32'(addr[SamRegionMsb:SamRegionLsb]) == i) begin
        dst = SamNodeIds[i];
      end
    end
    return dst;
  endfunction

  function automatic req_flit_t req_hdr(node_id_t dst, node_id_t src, axi_ch_e ch,
                                        logic last);
    req_flit_t flit;
    flit = '0;
    flit[ReqHdrLsb + HdrDstLsb +: NodeIdWidth] = dst;
    flit[ReqHdrLsb + HdrSrcLsb +: NodeIdWidth] = src;
    flit[ReqHdrLsb + HdrChLsb +: HdrChWidth]   = ch;
    flit[ReqHdrLsb + HdrLastBit]               = last;
    return flit;
  endfunction

  // AR is a packet of its own, AW always opens a write packet
  function automatic req_flit_t ax_flit(axi_ch_e ch, node_id_t dst, node_id_t src,
                                        axi_addr_t addr, axi_id_t id, axi_len_t len);
    req_flit_t flit;
    flit = req_hdr(dst, src, ch, ch == AXI_AR);
    flit[AxIdLsb +: IdWidth]     = id;
    flit[AxAddrLsb +: AddrWidth] = addr;
    flit[AxLenLsb +: LenWidth]   = len;
    return flit;
  endfunction

  assign aw_dst    = sam_lookup(aw_addr_i);
  assign ar_dst    = sam_lookup(ar_addr_i);
  assign aw_flit   = ax_flit(AXI_AW, aw_dst, node_id_i, aw_addr_i, aw_id_i, aw_len_i);
  assign ar_flit_o = ax_flit(AXI_AR, ar_dst, node_id_i, ar_addr_i, ar_id_i, ar_len_i);

  always_comb begin
    w_flit = req_hdr(w_dst_q, node_id_i, AXI_W, w_last_i);
    w_flit[WDataLsb +: DataWidth] = w_data_i;
    w_flit[WStrbLsb +: StrbWidth] = w_strb_i;
    w_flit[WLastBit]              = w_last_i;
  end

  //////////////////////////////////////////////////////////////////////
  // AW/W sequencing
  //////////////////////////////////////////////////////////////////////

  assign aw_ready_o = wa_grant_i && (sel_q == SEL_AW);
  assign w_ready_o  = wa_grant_i && (sel_q == SEL_W);
  assign ar_ready_o = ar_grant_i;
  assign wa_valid_o = (sel_q == SEL_AW) ? aw_valid_i : w_valid_i;
  assign wa_flit_o  = (sel_q == SEL_AW) ? aw_flit : w_flit;
  assign ar_valid_o = ar_valid_i;

  assign aw_xfer = aw_valid_i && aw_ready_o;
  assign w_xfer  = w_valid_i && w_ready_o;

  always_comb begin
    sel_d = sel_q;
    if (aw_xfer) begin
      sel_d = SEL_W;
    end else if (w_xfer && w_last_i) begin
      sel_d = SEL_AW;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q <= SEL_AW;
    end else begin
      sel_q <= sel_d;
    end
  end

  // W beats of the burst follow the AW to the same node
  always_ff @(posedge clk_i) begin
    if (aw_xfer) begin
      w_dst_q <= aw_dst;
    end
  end

endmodule

/* rtl/wormhole_arbiter.sv */
`timescale 1ns/1ps
/*
 * Round-robin arbiter for two request flit sources
 * Grant is held from the first flit of a packet to its last
 */
module wormhole_arbiter (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [1:0]            valid_i,
  input  noc_ni_pkg::req_flit_t flit0_i,
  input  noc_ni_pkg::req_flit_t flit1_i,
  output logic [1:0]            grant_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output noc_ni_pkg::req_flit_t req_flit_o
);
  import noc_ni_pkg::*;

  logic prio_q;
  logic lock_q, lock_src_q;
  logic sel, xfer, flit_last;

  // Locked source first, then the prioritized one
  always_comb begin
    if (lock_q) begin
      sel = lock_src_q;
    end else if (valid_i[prio_q]) begin
      sel = prio_q;
    end else begin
      sel = !prio_q;
    end
  end

  assign req_valid_o = valid_i[sel];
  assign req_flit_o  = sel ? flit1_i : flit0_i;
  assign grant_o[0]  = req_ready_i && !sel;
  assign grant_o[1]  = req_ready_i && sel;

  assign xfer      = req_valid_o && req_ready_i;
  assign flit_last = req_flit_o[ReqHdrLsb + HdrLastBit];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_src_q <= 1'b0;
    end else if (xfer) begin
      lock_q     <= !flit_last;
      lock_src_q <= sel;
      // Packet done so the other source goes first next time
      if (flit_last) begin
        prio_q <= !sel;
      end
    end
  end

  // A packet keeps its source until the last flit has gone
  a_packet_held: assert property (@(posedge clk_i) disable iff (reset_i)
    xfer && !flit_last |=> sel == $past(sel));

endmodule

/* rtl/rsp_unpacker.sv */
`timescale 1ns/1ps
/*
 * Response flit unpacker
 * Steers B and R flits onto the AXI B and R channels
 */
module rsp_unpacker (
  input  logic                  clk_i,
  input  logic                  rsp_valid_i,
  output logic                  rsp_ready_o,
  input  noc_ni_pkg::rsp_flit_t rsp_flit_i,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output noc_ni_pkg::axi_id_t   b_id_o,
  output noc_ni_pkg::axi_resp_t b_resp_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output noc_ni_pkg::axi_id_t   r_id_o,
  output noc_ni_pkg::axi_data_t r_data_o,
  output noc_ni_pkg::axi_resp_t r_resp_o,
  output logic                  r_last_o
);
  import noc_ni_pkg::*;

  axi_ch_e rsp_ch;
  logic    is_b, is_r;

  assign rsp_ch = axi_ch_e'(rsp_flit_i[RspHdrLsb + HdrChLsb +: HdrChWidth]);
  assign is_b   = (rsp_ch == AXI_B);
  assign is_r   = (rsp_ch == AXI_R);

  assign b_valid_o = rsp_valid_i && is_b;
  assign r_valid_o = rsp_valid_i && is_r;

  // Unknown channel codes are consumed so the link never locks up
  assign rsp_ready_o = is_b ? b_ready_i : (is_r ? r_ready_i : 1'b1);

  assign b_id_o   = rsp_flit_i[BIdLsb +: IdWidth];
  assign b_resp_o = rsp_flit_i[BRespLsb +: RespWidth];

  assign r_id_o   = rsp_flit_i[RIdLsb +: IdWidth];
  assign r_data_o = rsp_flit_i[RDataLsb +: DataWidth];
  assign r_resp_o = rsp_flit_i[RRespLsb +: RespWidth];
  assign r_last_o = rsp_flit_i[RLastBit];

  // Only B and R travel on the response network toward a manager port
  a_rsp_channel: assert property (@(posedge clk_i)
    rsp_valid_i |-> (is_b || is_r));

endmodule

/* rtl/noc_ni_top.sv */
`timescale 1ns/1ps
/*
 * Network interface top for one AXI4 manager
 * AX queues, flit packer, wormhole arbiter and response unpacker
 */
module noc_ni_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  noc_ni_pkg::node_id_t  node_id_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  noc_ni_pkg::axi_addr_t aw_addr_i,
  input  noc_ni_pkg::axi_id_t   aw_id_i,
  input  noc_ni_pkg::axi_len_t  aw_len_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  noc_ni_pkg::axi_data_t w_data_i,
  input  noc_ni_pkg::axi_strb_t w_strb_i,
  input  logic                  w_last_i,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output noc_ni_pkg::axi_id_t   b_id_o,
  output noc_ni_pkg::axi_resp_t b_resp_o,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  noc_ni_pkg::axi_addr_t ar_addr_i,
  input  noc_ni_pkg::axi_id_t   ar_id_i,
  input  noc_ni_pkg::axi_len_t  ar_len_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output noc_ni_pkg::axi_id_t   r_id_o,
  output noc_ni_pkg::axi_data_t r_data_o,
  output noc_ni_pkg::axi_resp_t r_resp_o,
  output logic                  r_last_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output noc_ni_pkg::req_flit_t req_flit_o,
  input  logic                  rsp_valid_i,
  output logic                  rsp_ready_o,
  input  noc_ni_pkg::rsp_flit_t rsp_flit_i
);
  import noc_ni_pkg::*;

  // Queued AW and AR requests
  logic      aw_q_valid, aw_q_ready, ar_q_valid, ar_q_ready;
  axi_addr_t aw_q_addr, ar_q_addr;
  axi_id_t   aw_q_id, ar_q_id;
  axi_len_t  aw_q_len, ar_q_len;

  // Packer to arbiter, source 0 is AW/W and source 1 is AR
  logic [1:0] arb_valid, arb_grant;
  req_flit_t  wa_flit, ar_flit;

  //////////////////////////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////////////////////////

  ax_spill_reg u_aw_queue (
    .clk_i,
    .reset_i,
    .valid_i ( aw_valid_i ),
    .ready_o ( aw_ready_o ),
    .addr_i  ( aw_addr_i  ),
    .id_i    ( aw_id_i    ),
    .len_i   ( aw_len_i   ),
    .valid_o ( aw_q_valid ),
    .ready_i ( aw_q_ready ),
    .addr_o  ( aw_q_addr  ),
    .id_o    ( aw_q_id    ),
    .len_o   ( aw_q_len   )
  );

  ax_spill_reg u_ar_queue (
    .clk_i,
    .reset_i,
    .valid_i ( ar_valid_i ),
    .ready_o ( ar_ready_o ),
    .addr_i  ( ar_addr_i  ),
    .id_i    ( ar_id_i    ),
    .len_i   ( ar_len_i   ),
    .valid_o ( ar_q_valid ),
    .ready_i ( ar_q_ready ),
    .addr_o  ( ar_q_addr  ),
    .id_o    ( ar_q_id    ),
    .len_o   ( ar_q_len   )
  );

  req_flit_packer u_packer (
    .clk_i,
    .reset_i,
    .node_id_i,
    .aw_valid_i ( aw_q_valid   ),
    .aw_ready_o ( aw_q_ready   ),
    .aw_addr_i  ( aw_q_addr    ),
    .aw_id_i    ( aw_q_id      ),
    .aw_len_i   ( aw_q_len     ),
    .w_valid_i,
    .w_ready_o,
    .w_data_i,
    .w_strb_i,
    .w_last_i,
    .ar_valid_i ( ar_q_valid   ),
    .ar_ready_o ( ar_q_ready   ),
    .ar_addr_i  ( ar_q_addr    ),
    .ar_id_i    ( ar_q_id      ),
    .ar_len_i   ( ar_q_len     ),
    .wa_valid_o ( arb_valid[0] ),
    .wa_grant_i ( arb_grant[0] ),
    .wa_flit_o  ( wa_flit      ),
    .ar_valid_o ( arb_valid[1] ),
    .ar_grant_i ( arb_grant[1] ),
    .ar_flit_o  ( ar_flit      )
  );

  wormhole_arbiter u_arbiter (
    .clk_i,
    .reset_i,
    .valid_i ( arb_valid ),
    .flit0_i ( wa_flit   ),
    .flit1_i ( ar_flit   ),
    .grant_o ( arb_grant ),
    .req_valid_o,
    .req_ready_i,
    .req_flit_o
  );

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  rsp_unpacker u_unpacker (
    .clk_i,
    .rsp_valid_i,
    .rsp_ready_o,
    .rsp_flit_i,
    .b_valid_o,
    .b_ready_i,
    .b_id_o,
    .b_resp_o,
    .r_valid_o,
    .r_ready_i,
    .r_id_o,
    .r_data_o,
    .r_resp_o,
    .r_last_o
  );

endmodule

/* bench/tb_noc_ni.sv */
`timescale 1ns/1ps
/*
 * Testbench for the NoC network interface
 * Clock and reset, AXI and link stimulus, reference flit model,
 * request link monitor and response channel checks
 */
module tb_noc_ni;
  import noc_ni_pkg::*;

  localparam node_id_t    SrcNode   = 4'd3;
  localparam int unsigned WaitLimit = 2000;

  logic      clk_i = 1'b0;
  logic      reset_i;
  node_id_t  node_id_i;
  logic      aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  axi_addr_t aw_addr_i, ar_addr_i;
  axi_id_t   aw_id_i, ar_id_i, b_id_o, r_id_o;
  axi_len_t  aw_len_i, ar_len_i;
  axi_data_t w_data_i, r_data_o;
  axi_strb_t w_strb_i;
  axi_resp_t b_resp_o, r_resp_o;
  logic      b_valid_o, b_ready_i, ar_valid_i, ar_ready_o;
  logic      r_valid_o, r_ready_i, r_last_o;
  logic      req_valid_o, req_ready_i, rsp_valid_i, rsp_ready_o;
  req_flit_t req_flit_o;
  rsp_flit_t rsp_flit_i;

  // Expected flits per source in issue order
  req_flit_t   wa_exp[$];
  req_flit_t   ar_exp[$];
  int unsigned errors = 0;
  int unsigned checks = 0;

  noc_ni_top u_noc_ni_top (.*);

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Top nibble 0 to 3 is mapped and everything else goes to node 0
  function automatic node_id_t ref_node(axi_addr_t addr);
    case (addr[31:28])
      4'h0: return 4'd5;
      4'h1: return 4'd6;
      4'h2: return 4'd9;
      4'h3: return 4'd10;
      default: return 4'd0;
    endcase
  endfunction

  function automatic req_flit_t ref_ax_flit(axi_ch_e ch, axi_addr_t addr, axi_id_t id,
                                            axi_len_t len);
    return {ref_node(addr), SrcNode, ch, ch == AXI_AR, 4'b0, id, addr, len};
  endfunction

  function automatic req_flit_t ref_w_flit(node_id_t dst, axi_data_t data, axi_strb_t strb,
                                           logic last);
    return {dst, SrcNode, AXI_W, last, 11'b0, data, strb, last};
  endfunction

  function automatic rsp_flit_t ref_rsp_flit(logic is_r, axi_id_t id, axi_data_t data,
                                             axi_resp_t resp, logic last);
    axi_ch_e ch;
    ch = is_r ? AXI_R : AXI_B;
    if (is_r) begin
      return {SrcNode, node_id_t'(9), ch, last, 1'b0, id, data, resp, last};
    end
    return {SrcNode, node_id_t'(9), ch, 1'b1, 34'b0, id, resp};
  endfunction

  function automatic axi_addr_t rand_addr();
    axi_addr_t addr;
    addr = $urandom;
    addr[31:28] = 4'($urandom_range(0, 5));
    return addr;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // Selects the ready of AW (0), W (1) or AR (2)
  task automatic wait_accept(input int which, input string what);
    int unsigned cycles;
    logic        rdy;
    cycles = 0;
    do begin
      @(posedge clk_i);
      case (which)
        0: rdy = aw_ready_o;
        1: rdy = w_ready_o;
        default: rdy = ar_ready_o;
      endcase
      cycles++;
      if (cycles > WaitLimit) stop_on_timeout(what);
    end while (!rdy);
  endtask

  task automatic wait_drained(input string what);
    int unsigned cycles;
    cycles = 0;
    while (wa_exp.size() != 0 || ar_exp.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > WaitLimit) stop_on_timeout(what);
    end
  endtask

  // Compares every request link transfer with the expected queues
  task automatic monitor_link();
    logic [HdrChWidth-1:0] ch;
    logic                  last;
    logic                  in_wpkt;
    in_wpkt = 1'b0;
    forever begin
      @(posedge clk_i);
      if (!reset_i && req_valid_o && req_ready_i) begin
        ch   = req_flit_o[ReqHdrLsb + HdrChLsb +: HdrChWidth];
        last = req_flit_o[ReqHdrLsb + HdrLastBit];
        if (ch == AXI_AR) begin
          if (in_wpkt) report_error("AR flit arrived inside a write packet");
          if (ar_exp.size() == 0) report_error("AR flit arrived with no read outstanding");
          else check_value("req_flit_o", 64'(req_flit_o), 64'(ar_exp.pop_front()));
        end else if (ch == AXI_AW || ch == AXI_W) begin
          if (wa_exp.size() == 0) report_error("AW or W flit arrived with no write outstanding");
          else check_value("req_flit_o", 64'(req_flit_o), 64'(wa_exp.pop_front()));
          in_wpkt = (ch == AXI_AW) || !last;
        end else begin
          report_error("request flit carries an unknown channel code");
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic do_write(input axi_addr_t addr, input axi_id_t id, input axi_len_t len);
    axi_data_t data;
    axi_strb_t strb;
    @(negedge clk_i);
    wa_exp.push_back(ref_ax_flit(AXI_AW, addr, id, len));
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = id;
    aw_len_i   = len;
    wait_accept(0, "AW accept");
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      data = $urandom;
      strb = axi_strb_t'($urandom);
      wa_exp.push_back(ref_w_flit(ref_node(addr), data, strb, i == int'(len)));
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      w_last_i  = (i == int'(len));
      wait_accept(1, "W accept");
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
  endtask

  task automatic do_read(input axi_addr_t addr, input axi_id_t id, input axi_len_t len);
    @(negedge clk_i);
    ar_exp.push_back(ref_ax_flit(AXI_AR, addr, id, len));
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = id;
    ar_len_i   = len;
    wait_accept(2, "AR accept");
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // Target channel stalls three cycles while the other channel is ready
  // For the last cycle the two readies swap
  task automatic check_rsp(input logic is_r, input axi_id_t id, input axi_data_t data,
                           input axi_resp_t resp, input logic last);
    @(negedge clk_i);
    rsp_flit_i  = ref_rsp_flit(is_r, id, data, resp, last);
    rsp_valid_i = 1'b1;
    b_ready_i   = is_r;
    r_ready_i   = !is_r;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      check_value("rsp_ready_o", 64'(rsp_ready_o), 64'(i == 3));
      check_value("b_valid_o", 64'(b_valid_o), 64'(!is_r));
      check_value("r_valid_o", 64'(r_valid_o), 64'(is_r));
      if (is_r) begin
        check_value("r_id_o", 64'(r_id_o), 64'(id));
        check_value("r_data_o", 64'(r_data_o), 64'(data));
        check_value("r_resp_o", 64'(r_resp_o), 64'(resp));
        check_value("r_last_o", 64'(r_last_o), 64'(last));
      end else begin
        check_value("b_id_o", 64'(b_id_o), 64'(id));
        check_value("b_resp_o", 64'(b_resp_o), 64'(resp));
      end
      if (i == 2) begin
        @(negedge clk_i);
        b_ready_i = !is_r;
        r_ready_i = is_r;
      end
    end
    @(negedge clk_i);
    rsp_valid_i = 1'b0;
  endtask

  initial begin
    logic writes_done;
    logic reads_done;
    void'($urandom(32'h93eb_0e9e));
    reset_i     = 1'b1;
    node_id_i   = SrcNode;
    aw_valid_i  = 1'b0;
    aw_addr_i   = '0;
    aw_id_i     = '0;
    aw_len_i    = '0;
    w_valid_i   = 1'b0;
    w_data_i    = '0;
    w_strb_i    = '0;
    w_last_i    = 1'b0;
    ar_valid_i  = 1'b0;
    ar_addr_i   = '0;
    ar_id_i     = '0;
    ar_len_i    = '0;
    b_ready_i   = 1'b1;
    r_ready_i   = 1'b1;
    req_ready_i = 1'b1;
    rsp_valid_i = 1'b0;
    rsp_flit_i  = '0;
    writes_done = 1'b0;
    reads_done  = 1'b0;
    fork
      monitor_link();
    join_none
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;

    // Idle state after reset
    @(posedge clk_i);
    check_value("req_valid_o", 64'(req_valid_o), 64'd0);
    check_value("b_valid_o", 64'(b_valid_o), 64'd0);
    check_value("r_valid_o", 64'(r_valid_o), 64'd0);
    check_value("aw_ready_o", 64'(aw_ready_o), 64'd1);
    check_value("ar_ready_o", 64'(ar_ready_o), 64'd1);

    // Single burst of four beats and then reads over mapped and unmapped regions
    do_write(32'h1000_0040, 4'h5, 8'd3);
    wait_drained("the write burst to drain");
    do_read(32'h0000_1000, 4'h1, 8'd0);
    do_read(32'h3000_0200, 4'h2, 8'd7);
    do_read(32'h8000_0000, 4'h3, 8'd1);
    do_read(32'hf000_fffc, 4'h4, 8'd0);
    wait_drained("the reads to drain");

    // Mixed traffic under random link back-pressure
    fork
      begin
        repeat (12) begin
          repeat ($urandom_range(0, 3)) @(negedge clk_i);
          do_write(rand_addr(), axi_id_t'($urandom), axi_len_t'($urandom_range(0, 4)));
        end
        writes_done = 1'b1;
      end
      begin
        repeat (16) begin
          repeat ($urandom_range(0, 3)) @(negedge clk_i);
          do_read(rand_addr(), axi_id_t'($urandom), axi_len_t'($urandom));
        end
        reads_done = 1'b1;
      end
      begin
        while (!(writes_done && reads_done)) begin
          @(negedge clk_i);
          req_ready_i = ($urandom_range(0, 3) != 0);
        end
      end
    join
    req_ready_i = 1'b1;
    wait_drained("the mixed traffic to drain");

    // Response link to B and R
    check_rsp(1'b0, 4'h7, '0, 2'b00, 1'b1);
    check_rsp(1'b0, 4'hc, '0, 2'b10, 1'b1);
    check_rsp(1'b1, 4'h2, 32'hdead_beef, 2'b00, 1'b0);
    check_rsp(1'b1, 4'h9, 32'h0123_4567, 2'b11, 1'b1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
rtl/noc_ni_pkg.sv
rtl/ax_spill_reg.sv
rtl/req_flit_packer.sv
rtl/wormhole_arbiter.sv
rtl/rsp_unpacker.sv
rtl/noc_ni_top.sv
bench/tb_noc_ni.sv

/* Makefile */
# Verilator lint and simulation of the NoC network interface

TOP := tb_noc_ni

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
